/* matrix_ctrl_top.f */
common/matrix_pkg.sv
control/control_cmd_decoder.sv
control/control_cmd_readrow.sv
logic/frame_buffer.sv
logic/matrix_ctrl_top.sv
tb/matrix_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the matrix controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module matrix_ctrl_tb -Mdir "$OBJ" \
    -f matrix_ctrl_top.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vmatrix_ctrl_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "simulation reported errors"
    exit 1
fi

echo "simulation clean"
exit 0

/* tb/matrix_ctrl_tb.sv */
/* testbench for the matrix controller top, table of read-row commands,
   byte model of the frame buffer and read-back compares */
`timescale 1ns/1ps
`default_nettype none

module matrix_ctrl_tb import matrix_pkg::*; ();

    localparam int NUM_ENTRIES   = 9;
    localparam int ROW_BYTES     = PIXEL_WIDTH * BYTES_PER_PIXEL;
    localparam int DONE_TIMEOUT  = 64;
    localparam int DONE_LATENCY  = 1;  // idle negedges before cmd_done shows
    localparam int IGNORED_BYTES = 4;

    typedef struct packed {
        byte_t      opcode;
        byte_t      row_byte;
        logic [3:0] gap;        // idle cycles before each byte after the opcode
        logic       expect_cmd;
    } entry_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     byte_valid;
    byte_t    byte_data;
    fb_addr_t rd_addr;
    logic     busy;
    logic     cmd_done;
    byte_t    rd_data;

    entry_t stim [NUM_ENTRIES];
    byte_t  model [FB_DEPTH];
    logic   row_written [PIXEL_HEIGHT];
    int     seed = 60;
    int     checks;
    int     mismatches;
    int     other_errors;
    logic   timed_out;
    int     e;
    int     r;

    matrix_ctrl_top uut (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .rd_addr    (rd_addr),
        .busy       (busy),
        .cmd_done   (cmd_done),
        .rd_data    (rd_data)
    );

    always #50 clk = ~clk;

    function automatic int model_index(int row, int col, int pix);
        return (row * PIXEL_WIDTH + col) * BYTES_PER_PIXEL + pix;
    endfunction

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h", what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h", what, got, exp);
        end
    endtask

    // ignored entries sample a row written earlier, row byte never 8'h10
    task automatic load_stim_table();
        stim[0] = '{8'h10, 8'h00, 4'd0, 1'b1};
        stim[1] = '{8'h10, 8'h1f, 4'd0, 1'b1};
        stim[2] = '{8'h10, 8'h05, 4'd3, 1'b1};
        stim[3] = '{8'h5a, 8'h1f, 4'd0, 1'b0};
        stim[4] = '{8'h10, 8'h10, 4'd0, 1'b1}; // row byte equal to the opcode
        stim[5] = '{8'h00, 8'h05, 4'd1, 1'b0};
        stim[6] = '{8'h10, 8'h05, 4'd0, 1'b1};
        stim[7] = '{8'h10, 8'he7, 4'd2, 1'b1}; // upper bits dropped, row 7
        stim[8] = '{8'h10, 8'h00, 4'd5, 1'b1};
    endtask

    task automatic strobe_byte(input byte_t b, input logic exp_busy);
        @(posedge clk);
        byte_valid <= 1'b1;
        byte_data  <= b;
        @(negedge clk);
        check_flag("busy", busy, exp_busy);
        check_flag("cmd_done", cmd_done, 1'b0);
    endtask

    task automatic idle_cycles(input int n, input logic exp_busy);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge clk);
            byte_valid <= 1'b0;
            @(negedge clk);
            check_flag("busy", busy, exp_busy);
            check_flag("cmd_done", cmd_done, 1'b0);
        end
    endtask

    task automatic send_readrow(input entry_t en, input int idx);
        row_addr_t row;
        byte_t     b;
        int        k;
        int        waited;
        row = en.row_byte[ROW_BITS-1:0];
        strobe_byte(en.opcode, 1'b0);
        idle_cycles(int'(en.gap), 1'b1);
        strobe_byte(en.row_byte, 1'b1);
        for (k = 0; k < ROW_BYTES; k++) begin
            b = byte_t'($random(seed));
            // right to left, last colour byte first
            model[model_index(int'(row), PIXEL_WIDTH - 1 - k / BYTES_PER_PIXEL,
                              BYTES_PER_PIXEL - 1 - k % BYTES_PER_PIXEL)] = b;
            idle_cycles(int'(en.gap), 1'b1);
            strobe_byte(b, 1'b1);
        end
        row_written[row] = 1'b1;
        @(posedge clk);
        byte_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (cmd_done !== 1'b1 && waited < DONE_TIMEOUT) begin
            check_flag("busy", busy, 1'b1);
            waited++;
            @(negedge clk);
        end
        if (cmd_done !== 1'b1) begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout: no cmd_done within %0d cycles on entry %0d",
                     DONE_TIMEOUT, idx);
        end else begin
            if (waited != DONE_LATENCY) begin
                other_errors++;
                $display("cmd_done came after %0d idle cycles on entry %0d, expected %0d",
                         waited, idx, DONE_LATENCY);
            end
            check_flag("busy", busy, 1'b1);
            @(negedge clk);
            check_flag("cmd_done", cmd_done, 1'b0); // single cycle pulse
            check_flag("busy", busy, 1'b0);
        end
    endtask

    task automatic send_unknown_opcode(input entry_t en);
        byte_t b;
        int    k;
        strobe_byte(en.opcode, 1'b0);
        idle_cycles(int'(en.gap), 1'b0);
        strobe_byte(en.row_byte, 1'b0);
        for (k = 0; k < IGNORED_BYTES; k++) begin
            b = byte_t'($random(seed));
            if (b == OPCODE_READROW) begin
                b = ~b; // would start a real command
            end
            idle_cycles(int'(en.gap), 1'b0);
            strobe_byte(b, 1'b0);
        end
        idle_cycles(4, 1'b0);
    endtask

    task automatic read_row(input row_addr_t row);
        int c;
        int p;
        for (c = 0; c < PIXEL_WIDTH; c++) begin
            for (p = 0; p < BYTES_PER_PIXEL; p++) begin
                @(posedge clk);
                rd_addr <= '{row, col_addr_t'(c), pixel_sel_t'(p)};
                @(posedge clk);
                @(negedge clk);
                check_byte($sformatf("rd_data row %0d col %0d pix %0d", row, c, p),
                           rd_data, model[model_index(int'(row), c, p)]);
            end
        end
    endtask

    initial begin
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        reset        = 1'b1;
        byte_valid   = 1'b0;
        byte_data    = '0;
        rd_addr      = '0;
        for (r = 0; r < PIXEL_HEIGHT; r++) begin
            row_written[r] = 1'b0;
        end
        load_stim_table();

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("cmd_done", cmd_done, 1'b0);

        for (e = 0; e < NUM_ENTRIES && !timed_out; e++) begin
            if (stim[e].expect_cmd) begin
                send_readrow(stim[e], e);
            end else begin
                send_unknown_opcode(stim[e]);
            end
            if (!timed_out) begin
                read_row(stim[e].row_byte[ROW_BITS-1:0]);
            end
        end

        // every written row once more, catches writes into neighbours
        if (!timed_out) begin
            for (r = 0; r < PIXEL_HEIGHT; r++) begin
                if (row_written[r]) begin
                    read_row(row_addr_t'(r));
                end
            end
        end

        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/matrix_ctrl_top.sv */
/* LED matrix pixel loader top, command decoder, read-row handler
   and frame buffer */
`timescale 1ns/1ps
`default_nettype none

module matrix_ctrl_top import matrix_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     byte_valid,
    input  byte_t    byte_data,
    input  fb_addr_t rd_addr,

    output logic     busy,
    output logic     cmd_done,
    output byte_t    rd_data
);

    logic       cmd_enable;
    byte_t      cmd_data;
    logic       readrow_done;
    row_addr_t  wr_row;
    col_addr_t  wr_column;
    pixel_sel_t wr_pixel;
    byte_t      wr_data;
    logic       wr_enable;
    logic       wr_toggle;

    control_cmd_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .done       (readrow_done),
        .cmd_enable (cmd_enable),
        .cmd_data   (cmd_data),
        .busy       (busy),
        .cmd_done   (cmd_done)
    );

    control_cmd_readrow u_readrow (
        .clk              (clk),
        .reset            (reset),
        .data_in          (cmd_data),
        .enable           (cmd_enable),
        .row              (wr_row),
        .column           (wr_column),
        .pixel            (wr_pixel),
        .data_out         (wr_data),
        .ram_write_enable (wr_enable),
        .ram_access_start (wr_toggle),
        .done             (readrow_done)
    );

    frame_buffer u_frame_buffer (
        .clk           (clk),
        .reset         (reset),
        .row           (wr_row),
        .column        (wr_column),
        .pixel         (wr_pixel),
        .wr_data       (wr_data),
        .write_enable  (wr_enable),
        .access_toggle (wr_toggle),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

endmodule

`default_nettype wire

/* logic/frame_buffer.sv */
/* byte-wide frame memory, written on access strobe toggles,
   synchronous read port for the scan-out side */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer import matrix_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  row_addr_t  row,
    input  col_addr_t  column,
    input  pixel_sel_t pixel,
    input  byte_t      wr_data,
    input  logic       write_enable,
    input  logic       access_toggle,
    input  fb_addr_t   rd_addr,

    output byte_t      rd_data
);

    localparam int IDX_BITS = $clog2(FB_DEPTH);

    typedef logic [IDX_BITS-1:0] fb_idx_t;

    byte_t   mem [FB_DEPTH];
    logic    last_toggle;
    logic    write_now;
    fb_idx_t wr_idx;
    fb_idx_t rd_idx;

    // row-major, columns then colour bytes
    function automatic fb_idx_t linear_index(row_addr_t r, col_addr_t c, pixel_sel_t p);
        return fb_idx_t'((int'(r) * PIXEL_WIDTH + int'(c)) * BYTES_PER_PIXEL + int'(p));
    endfunction

    assign wr_idx    = linear_index(row, column, pixel);
    assign rd_idx    = linear_index(rd_addr.row, rd_addr.column, rd_addr.pixel);
    assign write_now = write_enable && (access_toggle != last_toggle);

    always_ff @(posedge clk) begin
        if (reset) begin
            last_toggle <= 1'b0;
        end else begin
            last_toggle <= access_toggle;
        end
    end

    always_ff @(posedge clk) begin
        if (write_now) begin
            mem[wr_idx] <= wr_data;
        end
        rd_data <= mem[rd_idx]; // old byte on same-cycle collision
    end

    assert property (@(posedge clk) disable iff (reset)
        write_now |-> (int'(pixel) < BYTES_PER_PIXEL));

endmodule

`default_nettype wire

/* control/control_cmd_readrow.sv */
/* read-row command handler, row capture and per-byte frame buffer
   address sequencing with a toggling access strobe */
`timescale 1ns/1ps
`default_nettype none

module control_cmd_readrow import matrix_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  byte_t      data_in,
    input  logic       enable,

    output row_addr_t  row,
    output col_addr_t  column,
    output pixel_sel_t pixel,
    output byte_t      data_out,
    output logic       ram_write_enable,
    output logic       ram_access_start,
    output logic       done
);

    typedef enum logic [1:0] {
        ST_ROW_CAPTURE,
        ST_PRIME_WRITE,
        ST_ROW_CONTENT,
        ST_DONE
    } rr_state_t;

    localparam col_addr_t  LAST_COL = col_addr_t'(PIXEL_WIDTH - 1);
    localparam pixel_sel_t LAST_PIX = pixel_sel_t'(BYTES_PER_PIXEL - 1);

    rr_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= ST_ROW_CAPTURE;
            row              <= '0;
            column           <= '0;
            pixel            <= '0;
            data_out         <= '0;
            ram_write_enable <= 1'b0;
            ram_access_start <= 1'b0;
            done             <= 1'b0;
        end else begin
            case (state)
                ST_ROW_CAPTURE: begin
                    if (enable) begin
                        row              <= data_in[ROW_BITS-1:0];
                        ram_write_enable <= 1'b0;
                        state            <= ST_PRIME_WRITE;
                    end
                end
                ST_PRIME_WRITE: begin
                    if (enable) begin
                        // first byte goes to the rightmost pixel, last channel
                        column           <= LAST_COL;
                        pixel            <= LAST_PIX;
                        data_out         <= data_in;
                        ram_write_enable <= 1'b1;
                        ram_access_start <= !ram_access_start;
                        state            <= ST_ROW_CONTENT;
                    end
                end
                ST_ROW_CONTENT: begin
                    if (enable) begin
                        data_out         <= data_in;
                        ram_access_start <= !ram_access_start;
                        if (pixel == '0) begin
                            pixel  <= LAST_PIX; // wrap to previous column
                            column <= column - 1'b1;
                        end else begin
                            pixel <= pixel - 1'b1;
                        end
                        if (column == '0 && pixel == pixel_sel_t'(1)) begin
                            done  <= 1'b1; // this byte lands at column 0, pixel 0
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    // write enable held here so the last toggle is still taken
                    done             <= 1'b0;
                    ram_write_enable <= 1'b0;
                    state            <= ST_ROW_CAPTURE;
                end
                default: state <= ST_ROW_CAPTURE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

    // column only steps down while writes are armed
    assert property (@(posedge clk) disable iff (reset)
        (ram_write_enable && $past(ram_write_enable)) |-> (column <= $past(column)));

endmodule

`default_nettype wire

/* control/control_cmd_decoder.sv */
/* command byte stream decoder, detects the read-row opcode and
   forwards the following bytes to the command handler */
`timescale 1ns/1ps
`default_nettype none

module control_cmd_decoder import matrix_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  byte_valid,
    input  byte_t byte_data,
    input  logic  done,

    output logic  cmd_enable,
    output byte_t cmd_data,
    output logic  busy,
    output logic  cmd_done
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } dec_state_t;

    dec_state_t state;
    logic       is_readrow;

    assign is_readrow = byte_valid && (byte_data == OPCODE_READROW);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            cmd_enable <= 1'b0;
        end else begin
            cmd_enable <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (is_readrow) begin
                        state <= ST_RUN; // other opcodes dropped
                    end
                end
                ST_RUN: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end else begin
                        cmd_enable <= byte_valid; // opcode values pass as data here
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            cmd_data <= byte_data;
        end
    end

    assign busy     = (state == ST_RUN);
    assign cmd_done = done && (state == ST_RUN);

    // nothing reaches the handler unless a command was started
    assert property (@(posedge clk) disable iff (reset)
        (state == ST_IDLE) |-> !cmd_enable);

endmodule

`default_nettype wire

/* common/matrix_pkg.sv */
/* panel geometry, command opcode values, byte and address types,
   frame buffer read address struct */
`default_nettype none

package matrix_pkg;

    // panel geometry
    localparam int PIXEL_HEIGHT    = 32;
    localparam int PIXEL_WIDTH     = 64;
    localparam int BYTES_PER_PIXEL = 3;

    localparam int ROW_BITS    = 5;
    localparam int COL_BITS    = 6;
    localparam int PIXSEL_BITS = 2;

    // one byte per colour channel per pixel
    localparam int FB_DEPTH = PIXEL_HEIGHT * PIXEL_WIDTH * BYTES_PER_PIXEL;

    // command opcodes
    localparam logic [7:0] OPCODE_READROW = 8'h10;

    typedef logic [7:0] byte_t;

    typedef logic [ROW_BITS-1:0]    row_addr_t;
    typedef logic [COL_BITS-1:0]    col_addr_t;
    typedef logic [PIXSEL_BITS-1:0] pixel_sel_t;

    // scan-out side address of one colour byte
    typedef struct packed {
        row_addr_t  row;
        col_addr_t  column;
        pixel_sel_t pixel;
    } fb_addr_t;

endpackage

`default_nettype wire
